/* Bender.yml */
package:
  name: afu_line_reader

sources:
  - include_dirs:
      - logic
    files:
      - logic/afu_pkg.sv
      - logic/csr_if.sv
      - logic/mmio_csr.sv
      - logic/line_reader.sv
      - logic/afu_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/afu_checker.sv
      - bench/host_mem_model.sv
      - bench/afu_tb.sv

/* bench/afu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "afu_params.svh"

module afu_checker (
  input logic clk,
  input logic rst_n,
  input logic c0_almost_full,
  input logic c0_valid,
  input logic rsp_valid,
  input logic mmio_rd_valid,
  input logic mmio_wr_valid,
  input logic c2_valid
);

  int unsigned fail_count = 0; // failed assertions so far
  logic [7:0]  inflight;       // requests out minus responses back

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inflight <= '0;
    end else begin
      inflight <= inflight + c0_valid - rsp_valid;
    end
  end

  // almost full seen on one edge blocks a request on the next
  issue_after_full: assert property (@(posedge clk) disable iff (!rst_n)
    c0_almost_full |=> !c0_valid)
    else begin
      fail_count++;
      $error("c0_valid one cycle after c0_almost_full");
    end

  one_rx_event: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({mmio_rd_valid, mmio_wr_valid, rsp_valid}))
    else begin
      fail_count++;
      $error("more than one rx strobe in a cycle");
    end

  read_answered: assert property (@(posedge clk) disable iff (!rst_n)
    mmio_rd_valid |=> c2_valid)
    else begin
      fail_count++;
      $error("mmio read without c2 response one cycle later");
    end

  inflight_capped: assert property (@(posedge clk) disable iff (!rst_n)
    inflight <= `MAX_OUTSTANDING)
    else begin
      fail_count++;
      $error("too many reads in flight");
    end

endmodule

bind afu_top afu_checker afu_checker_inst (
  .clk            (clk),
  .rst_n          (rst_n),
  .c0_almost_full (c0_almost_full),
  .c0_valid       (c0_valid),
  .rsp_valid      (rsp_valid),
  .mmio_rd_valid  (mmio_rd_valid),
  .mmio_wr_valid  (mmio_wr_valid),
  .c2_valid       (c2_valid)
);

`default_nettype wire

/* bench/afu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "afu_params.svh"

module afu_tb
  import afu_pkg::*;
();

  localparam int NUM_FETCHES = 8;
  localparam int MAX_LINES   = 64;
  localparam int MAX_CYCLES  = NUM_FETCHES * 2500; // 64 lines under back-pressure plus polling
  localparam logic [127:0] UUID = `AFU_UUID;

  logic          clk, rst_n, hold;
  logic          mmio_rd_valid, mmio_wr_valid, rsp_valid;
  mmio_req_hdr_t mmio_hdr;
  logic [63:0]   mmio_wdata;
  rd_rsp_hdr_t   rsp_hdr;
  logic [511:0]  rsp_data;
  rx_hdr_u       rx_hdr;
  logic [511:0]  rx_data;
  logic          c0_almost_full, c0_valid, c2_valid;
  logic [63:0]   c0_addr, c2_data;
  logic [15:0]   c0_mdata, mem_index;
  logic [8:0]    c2_tid;
  logic          buf_addr_valid, mem_data_valid;
  logic [511:0]  mem_data;

  int          cycles = 0;
  logic [63:0] fetch_base;           // line 0 address of the current fetch
  int          fetch_num;
  bit          seen [MAX_LINES];     // indices delivered so far
  int          seen_count, issued_count, inflight;

  // responses and mmio share the rx header word but never a cycle
  always_comb begin
    if (rsp_valid) begin
      rx_hdr.rsp = rsp_hdr;
      rx_data    = rsp_data;
    end else begin
      rx_hdr.mmio = mmio_hdr;
      rx_data     = {448'h0, mmio_wdata};
    end
  end

  afu_top afu_top_inst (.*);
  host_mem_model host_mem_model_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s at %0t", why, $time);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_value(input string name, input logic [511:0] got,
                               input logic [511:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      fail_run("value check failed");
    end
  endtask

  // each lane is the line address with the lane number folded into its top byte
  function automatic logic [511:0] expected_line(input logic [63:0] addr);
    logic [511:0] line;
    for (int lane = 0; lane < 8; lane++) begin
      line[lane*64 +: 64] = {addr[63:56] ^ 8'(lane), addr[55:0]};
    end
    return line;
  endfunction

  task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
    hold <= 1'b1;                    // keep the host model off the rx header
    @(posedge clk);
    mmio_hdr.address <= addr;
    mmio_hdr.tid     <= '0;
    mmio_wdata       <= data;
    mmio_wr_valid    <= 1'b1;
    @(negedge clk);
    compare_value("buf_addr_valid", buf_addr_valid, addr == `CSR_BUF_ADDR);
    @(posedge clk);
    mmio_wr_valid <= 1'b0;
    hold          <= 1'b0;
  endtask

  task automatic mmio_read(input logic [15:0] addr, output logic [63:0] data);
    logic [8:0] tid;
    tid = 9'($urandom);
    hold <= 1'b1;
    @(posedge clk);
    mmio_hdr.address <= addr;
    mmio_hdr.tid     <= tid;
    mmio_rd_valid    <= 1'b1;
    @(negedge clk);
    compare_value("c2_valid", c2_valid, 1'b0); // no response in the request cycle
    @(posedge clk);
    mmio_rd_valid <= 1'b0;
    hold          <= 1'b0;
    @(negedge clk);
    compare_value("c2_valid", c2_valid, 1'b1);
    compare_value("c2_tid", c2_tid, tid);
    data = c2_data;
    @(posedge clk);
  endtask

  task automatic read_expect(input logic [15:0] addr, input logic [63:0] exp);
    logic [63:0] got;
    mmio_read(addr, got);
    compare_value($sformatf("c2_data at offset %h", addr), got, exp);
  endtask

  task automatic clear_fetch();
    foreach (seen[i]) seen[i] = 1'b0;
    seen_count   = 0;
    issued_count = 0;
  endtask

  // monitor on the falling edge where outputs are stable
  always @(negedge clk) begin
    if (rst_n) begin
      if (afu_top_inst.afu_checker_inst.fail_count != 0) begin
        fail_run("protocol assertion failed in the bound checker");
      end
      if (c0_valid) begin
        compare_value("c0_mdata", c0_mdata, issued_count); // lines go out in index order
        compare_value("c0_addr", c0_addr, fetch_base + 64'(issued_count));
        issued_count++;
        inflight++;
      end
      if (rsp_valid) inflight--;
      if (inflight > `MAX_OUTSTANDING) fail_run("more reads in flight than allowed");
      if (buf_addr_valid && !mmio_wr_valid) fail_run("buf_addr_valid without a write");
      if (mem_data_valid) begin
        if (mem_index >= fetch_num || seen[mem_index]) begin
          fail_run("line index outside the fetch or delivered twice");
        end else begin
          seen[mem_index] = 1'b1;
          seen_count++;
          compare_value("mem_data", mem_data, expected_line(fetch_base + mem_index));
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) fail_run("timeout, fetches did not complete");
  end

  initial begin
    logic [63:0] word, restart_addr;
    dfh_t        exp_dfh;
    int          num;
    void'($urandom(32'h3537));
    rst_n         = 1'b0;
    hold          = 1'b0;
    mmio_rd_valid = 1'b0;
    mmio_wr_valid = 1'b0;
    mmio_hdr      = '0;
    mmio_wdata    = '0;
    fetch_base    = '0;
    fetch_num     = 0;
    inflight      = 0;
    clear_fetch();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    exp_dfh = '0;
    exp_dfh.feature_type = 4'h1; // afu type
    exp_dfh.eol = 1'b1;          // last in the feature list
    read_expect(`CSR_DFH, exp_dfh);
    read_expect(`CSR_ID_L, UUID[63:0]);
    read_expect(`CSR_ID_H, UUID[127:64]);
    read_expect(16'h0006, 64'h0);
    read_expect(16'h0008, 64'h0);
    read_expect({8'h01, 8'($urandom)}, 64'h0); // unmapped
    read_expect(`CSR_STATUS, 64'h0);

    // zero-line fetches while the address register is exercised
    mmio_write(`CSR_NUM_LINES, 64'h0);
    repeat (4) begin
      word = {$urandom, $urandom};
      mmio_write(`CSR_BUF_ADDR, word);
      read_expect(`CSR_BUF_ADDR, word);
    end
    repeat (4) begin
      word = {$urandom, $urandom};
      mmio_write(`CSR_NUM_LINES, word);
      read_expect(`CSR_NUM_LINES, {48'h0, word[15:0]});
    end

    for (int f = 0; f < NUM_FETCHES; f++) begin
      num = $urandom_range(0, MAX_LINES);
      clear_fetch();
      fetch_num  = num;
      fetch_base = {$urandom, $urandom};
      restart_addr = fetch_base;
      mmio_write(`CSR_NUM_LINES, 64'(num));
      mmio_write(`CSR_BUF_ADDR, fetch_base);
      if (num >= 8) begin // still busy two cycles later
        restart_addr = ~fetch_base;
        mmio_write(`CSR_BUF_ADDR, restart_addr);
      end
      do mmio_read(`CSR_STATUS, word); while (word[16]);
      compare_value("lines_done", word[15:0], num);
      compare_value("lines issued", issued_count, num);
      compare_value("lines delivered", seen_count, num);
      read_expect(`CSR_BUF_ADDR, restart_addr); // register follows the last write
    end

    if (afu_top_inst.afu_checker_inst.fail_count == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      fail_run("protocol assertion failed in the bound checker");
    end
  end

endmodule

`default_nettype wire

/* bench/host_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module host_mem_model
  import afu_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         hold,           // rx header taken by an mmio access
  input  logic         c0_valid,
  input  logic [63:0]  c0_addr,
  input  logic [15:0]  c0_mdata,
  output logic         c0_almost_full,
  output logic         rsp_valid,
  output rd_rsp_hdr_t  rsp_hdr,
  output logic [511:0] rsp_data
);

  logic [63:0] pend_addr[$];   // requests not yet answered
  logic [15:0] pend_tag[$];
  int          pick;

  // host memory contents, lane number in the top byte of each lane
  function automatic logic [511:0] line_pattern(input logic [63:0] addr);
    logic [511:0] line;
    for (int lane = 0; lane < 8; lane++) begin
      line[lane*64 +: 64] = addr ^ {8'(lane), 56'h0};
    end
    return line;
  endfunction

  initial begin
    c0_almost_full = 1'b0;
    rsp_valid      = 1'b0;
    rsp_hdr        = '0;
    rsp_data       = '0;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      pend_addr.delete();
      pend_tag.delete();
      c0_almost_full <= 1'b0;
      rsp_valid      <= 1'b0;
    end else begin
      if (c0_valid) begin
        pend_addr.push_back(c0_addr);
        pend_tag.push_back(c0_mdata);
      end
      c0_almost_full <= ($urandom_range(0, 4) == 0); // random back-pressure
      rsp_valid      <= 1'b0;
      // answer a random pending request, some cycles skipped for delay
      if (!hold && pend_addr.size() != 0 && $urandom_range(0, 2) == 0) begin
        pick      = $urandom_range(0, pend_addr.size() - 1);
        rsp_valid <= 1'b1;
        rsp_hdr   <= '{resp_type: 4'h0, reserved: 8'h0, mdata: pend_tag[pick]};
        rsp_data  <= line_pattern(pend_addr[pick]);
        pend_addr.delete(pick);
        pend_tag.delete(pick);
      end
    end
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+logic
logic/afu_pkg.sv
logic/csr_if.sv
logic/mmio_csr.sv
logic/line_reader.sv
logic/afu_top.sv
bench/afu_checker.sv
bench/host_mem_model.sv
bench/afu_tb.sv

/* logic/afu_params.svh */
`ifndef AFU_PARAMS_SVH
`define AFU_PARAMS_SVH

// identifier the host driver matches against, low half at CSR_ID_L
`define AFU_UUID 128'h8f3a_61c2_4d7e_4b09_a5d1_2e6c_90b7_f314

// mmio offsets in 32-bit word units, every register is 64 bits wide
`define CSR_DFH       16'h0000
`define CSR_ID_L      16'h0002
`define CSR_ID_H      16'h0004
`define CSR_BUF_ADDR  16'h000A // cache-line address of the source buffer
`define CSR_NUM_LINES 16'h000C // lines to fetch
`define CSR_STATUS    16'h000E // {busy, lines_done}

// fetch engine limits
`define MAX_OUTSTANDING 16     // reads in flight at once
`define LINE_IDX_W      16     // width of line count and line index

`endif

/* logic/afu_pkg.sv */
`default_nettype none

package afu_pkg;

  // mmio request header, arrives on the shared rx header word
  typedef struct packed {
    logic [15:0] address;   // word offset
    logic [1:0]  length;    // access size, only 64-bit is handled
    logic        reserved;
    logic [8:0]  tid;       // echoed back on c2
  } mmio_req_hdr_t;

  // read response header, same 28 bits as the mmio header
  typedef struct packed {
    logic [3:0]  resp_type;
    logic [7:0]  reserved;
    logic [15:0] mdata;     // tag returned from the request
  } rd_rsp_hdr_t;

  // one rx header word, meaning set by which strobe is high
  typedef union packed {
    mmio_req_hdr_t mmio;    // with mmio_rd_valid or mmio_wr_valid
    rd_rsp_hdr_t   rsp;     // with rsp_valid
  } rx_hdr_u;

  // device feature header at offset 0
  typedef struct packed {
    logic [3:0]  feature_type; // 1 = afu
    logic [7:0]  reserved;
    logic [3:0]  minor_rev;
    logic [6:0]  reserved_lo;
    logic        eol;          // last entry of the dfh list
    logic [23:0] next_offset;
    logic [3:0]  major_rev;
    logic [11:0] feature_id;
  } dfh_t;

endpackage

`default_nettype wire

/* logic/afu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module afu_top
  import afu_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  // receive side, one header word for all three events
  input  rx_hdr_u      rx_hdr,
  input  logic [511:0] rx_data,
  input  logic         mmio_rd_valid,
  input  logic         mmio_wr_valid,
  input  logic         rsp_valid,
  // read request channel
  input  logic         c0_almost_full,
  output logic         c0_valid,
  output logic [63:0]  c0_addr,
  output logic [15:0]  c0_mdata,
  // mmio response channel
  output logic         c2_valid,
  output logic [8:0]   c2_tid,
  output logic [63:0]  c2_data,
  // fetched lines
  output logic         buf_addr_valid,
  output logic         mem_data_valid,
  output logic [511:0] mem_data,
  output logic [15:0]  mem_index
);

  // fetch control and status between the two blocks
  csr_if ctl_if ();

  mmio_csr mmio_csr_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .rx_hdr         (rx_hdr),
    .wr_data        (rx_data[63:0]),  // mmio writes use the low lane
    .mmio_rd_valid  (mmio_rd_valid),
    .mmio_wr_valid  (mmio_wr_valid),
    .c2_valid       (c2_valid),
    .c2_tid         (c2_tid),
    .c2_data        (c2_data),
    .buf_addr_valid (buf_addr_valid),
    .ctl            (ctl_if.csr)
  );

  line_reader line_reader_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .rx_hdr         (rx_hdr),
    .rx_data        (rx_data),
    .rsp_valid      (rsp_valid),
    .c0_almost_full (c0_almost_full),
    .c0_valid       (c0_valid),
    .c0_addr        (c0_addr),
    .c0_mdata       (c0_mdata),
    .mem_data_valid (mem_data_valid),
    .mem_data       (mem_data),
    .mem_index      (mem_index),
    .ctl            (ctl_if.reader)
  );

endmodule

`default_nettype wire

/* logic/csr_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "afu_params.svh"

interface csr_if;

  logic                   start;      // one-cycle fetch request
  logic [63:0]            base_addr;  // cache-line address of line 0
  logic [`LINE_IDX_W-1:0] num_lines;  // lines to fetch
  logic [`LINE_IDX_W-1:0] lines_done; // lines returned so far
  logic                   busy;       // fetch in progress

  // register block side
  modport csr (
    output start,
    output base_addr,
    output num_lines,
    input  lines_done,
    input  busy
  );

  // fetch engine side
  modport reader (
    input  start,
    input  base_addr,
    input  num_lines,
    output lines_done,
    output busy
  );

endinterface

`default_nettype wire

/* logic/line_reader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "afu_params.svh"

module line_reader
  import afu_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  rx_hdr_u      rx_hdr,         // rsp view only
  input  logic [511:0] rx_data,
  input  logic         rsp_valid,
  input  logic         c0_almost_full, // host read queue nearly full
  output logic         c0_valid,
  output logic [63:0]  c0_addr,        // cache-line address
  output logic [15:0]  c0_mdata,       // line index as tag
  output logic         mem_data_valid,
  output logic [511:0] mem_data,
  output logic [15:0]  mem_index,
  csr_if.reader        ctl
);

  localparam int IW    = `LINE_IDX_W;
  localparam int OUT_W = $clog2(`MAX_OUTSTANDING + 1);
  localparam logic [OUT_W-1:0] OUT_MAX = OUT_W'(`MAX_OUTSTANDING);

  rd_rsp_hdr_t      rsp_hdr;
  logic             busy_q;
  logic [63:0]      base_q;      // latched buffer address
  logic [IW-1:0]    total_q;     // latched line count
  logic [IW-1:0]    issued_q;    // requests sent
  logic [IW-1:0]    done_q;      // responses received
  logic [OUT_W-1:0] outst_q;     // requests in flight
  logic             launch;      // start seen while idle
  logic             more;        // lines left and room in flight
  logic             issue;       // send a request this cycle
  logic [IW-1:0]    issue_idx;
  logic [63:0]      issue_addr;
  logic             rsp_ok;      // response counted for this fetch

  assign rsp_hdr = rx_hdr.rsp;

  assign launch = ctl.start && !busy_q; // restart while busy is dropped
  assign more   = busy_q && (issued_q != total_q) && (outst_q < OUT_MAX);

  // first request goes out in the start cycle itself
  assign issue = !c0_almost_full && ((launch && (ctl.num_lines != '0)) || more);

  assign issue_idx  = launch ? '0 : issued_q;
  assign issue_addr = (launch ? ctl.base_addr : base_q) + {{(64 - IW){1'b0}}, issue_idx};

  assign rsp_ok = rsp_valid && busy_q;

  // request channel
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      c0_valid <= 1'b0;
      c0_addr  <= '0;
      c0_mdata <= '0;
    end else begin
      c0_valid <= issue;
      if (issue) begin
        c0_addr  <= issue_addr;
        c0_mdata <= issue_idx;
      end
    end
  end

  // response delivery, order as returned by the host
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_data_valid <= 1'b0;
      mem_data       <= '0;
      mem_index      <= '0;
    end else begin
      mem_data_valid <= rsp_valid;
      if (rsp_valid) begin
        mem_data  <= rx_data;
        mem_index <= rsp_hdr.mdata; // tag is the line index
      end
    end
  end

  // fetch bookkeeping
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q   <= 1'b0;
      base_q   <= '0;
      total_q  <= '0;
      issued_q <= '0;
      done_q   <= '0;
      outst_q  <= '0;
    end else if (launch) begin
      base_q   <= ctl.base_addr;
      total_q  <= ctl.num_lines;
      done_q   <= '0;
      busy_q   <= (ctl.num_lines != '0); // zero lines is done at once
      issued_q <= {{(IW - 1){1'b0}}, issue};
      outst_q  <= {{(OUT_W - 1){1'b0}}, issue};
    end else begin
      if (issue) begin
        issued_q <= issued_q + 1'b1;
      end
      if (rsp_ok) begin
        done_q <= done_q + 1'b1;
        if (done_q + 1'b1 == total_q) begin
          busy_q <= 1'b0; // last line back, all were issued
        end
      end
      case ({issue, rsp_ok})
        2'b10:   outst_q <= outst_q + 1'b1;
        2'b01:   outst_q <= outst_q - 1'b1;
        default: ; // none, or one in and one out
      endcase
    end
  end

  assign ctl.busy       = busy_q;
  assign ctl.lines_done = done_q;

endmodule

`default_nettype wire

/* logic/mmio_csr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "afu_params.svh"

module mmio_csr
  import afu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  rx_hdr_u     rx_hdr,         // mmio view only
  input  logic [63:0] wr_data,        // low lane of rx data
  input  logic        mmio_rd_valid,
  input  logic        mmio_wr_valid,
  output logic        c2_valid,       // mmio read response
  output logic [8:0]  c2_tid,
  output logic [63:0] c2_data,
  output logic        buf_addr_valid, // same cycle as the address write
  csr_if.csr          ctl
);

  localparam logic [127:0] AFU_ID = `AFU_UUID;

  mmio_req_hdr_t          mmio_hdr;
  dfh_t                   dfh;
  logic [63:0]            buffer_addr;  // last written buffer address
  logic [`LINE_IDX_W-1:0] num_lines;    // programmed line count
  logic                   start_q;      // address write, one cycle late
  logic [63:0]            status_word;
  logic [63:0]            rd_word;      // read mux output

  assign mmio_hdr = rx_hdr.mmio;

  // afu type, end of list, no further features
  assign dfh = '{feature_type: 4'h1, eol: 1'b1, default: '0};

  assign status_word = {{(64 - `LINE_IDX_W - 1){1'b0}}, ctl.busy, ctl.lines_done};

  // read data select
  always_comb begin
    case (mmio_hdr.address)
      `CSR_DFH:       rd_word = dfh;
      `CSR_ID_L:      rd_word = AFU_ID[63:0];
      `CSR_ID_H:      rd_word = AFU_ID[127:64];
      `CSR_BUF_ADDR:  rd_word = buffer_addr;
      `CSR_NUM_LINES: rd_word = {{(64 - `LINE_IDX_W){1'b0}}, num_lines};
      `CSR_STATUS:    rd_word = status_word;
      default:        rd_word = 64'h0; // 0x0006, 0x0008 and unmapped
    endcase
  end

  // write strobe for the buffer address, combinational
  assign buf_addr_valid = mmio_wr_valid && (mmio_hdr.address == `CSR_BUF_ADDR);

  // read response path, one cycle after the request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      c2_valid <= 1'b0;
      c2_tid   <= '0;
      c2_data  <= '0;
    end else begin
      c2_valid <= mmio_rd_valid;
      if (mmio_rd_valid) begin
        c2_tid  <= mmio_hdr.tid; // echo the request tid
        c2_data <= rd_word;
      end
    end
  end

  // writable registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buffer_addr <= '0;
      num_lines   <= '0;
    end else if (mmio_wr_valid) begin
      case (mmio_hdr.address)
        `CSR_BUF_ADDR:  buffer_addr <= wr_data;
        `CSR_NUM_LINES: num_lines   <= wr_data[`LINE_IDX_W-1:0];
        default:        ; // read-only or unmapped
      endcase
    end
  end

  // fetch kick, lands when buffer_addr already holds the new value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_q <= 1'b0;
    end else begin
      start_q <= buf_addr_valid;
    end
  end

  assign ctl.start     = start_q;
  assign ctl.base_addr = buffer_addr;
  assign ctl.num_lines = num_lines;

endmodule

`default_nettype wire
